/* rtl/snowball_pkg.sv */
/*
 * Shared cache geometry
 *  - address split into tag, line index and bank select
 *  - bank count and lines per bank
 *  - typedefs for addresses, data words, tags, indices and bank numbers
 */
package snowball_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int ADDR_W    = 32;  // Word address
  localparam int DATA_W    = 32;  // Data word

  // ------------------------------------------------------------
  // Address split: tag | index | bank
  // ------------------------------------------------------------
  localparam int NUM_BANKS = 4;
  localparam int BANK_W    = 2;   // Bits 1..0
  localparam int INDEX_W   = 6;   // Bits 7..2
  localparam int LINES     = 64;  // 2**INDEX_W
  localparam int TAG_W     = 24;  // Bits 31..8

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------
  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [BANK_W-1:0]  bank_sel_t;

endpackage

/* rtl/cache_request_steer.sv */
/*
 * CPU request steering
 *  - accepts one request at a time and holds busy until done
 *  - registers the request fields for the banks
 *  - one-cycle one-hot request pulse to the selected bank
 */
`timescale 1ns/1ns

module cache_request_steer
(
  input  logic                               CPU_CLK,
  input  logic                               RST,
  input  logic                               cpu_en,
  input  logic                               cpu_we,
  input  logic                               cpu_force_miss,
  input  snowball_pkg::addr_t                cpu_addr,
  input  snowball_pkg::data_t                cpu_wdata,
  input  logic                               cpu_done,
  output logic                               cpu_busy,
  output logic [snowball_pkg::NUM_BANKS-1:0] bank_req,
  output logic                               req_we,
  output logic                               req_force_miss,
  output snowball_pkg::addr_t                req_addr,
  output snowball_pkg::data_t                req_wdata
);

  logic                    accept;
  snowball_pkg::bank_sel_t bank_sel;

  assign accept   = cpu_en && !cpu_busy;                    // Enable while busy is dropped
  assign bank_sel = cpu_addr[snowball_pkg::BANK_W-1:0];     // Low word bits pick the bank

  // ------------------------------------------------------------
  // Busy flag and bank request pulse
  // ------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      cpu_busy <= 1'b0;
      bank_req <= '0;
    end
    else
    begin
      bank_req <= '0;                                       // Pulse lasts one cycle
      if (accept)
      begin
        cpu_busy           <= 1'b1;
        bank_req[bank_sel] <= 1'b1;
      end
      else if (cpu_done)
        cpu_busy <= 1'b0;                                   // Free again one cycle after done
    end
  end

  // Request fields stay put until the next acceptance
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      req_we         <= cpu_we;
      req_force_miss <= cpu_force_miss;
      req_addr       <= cpu_addr;
      req_wdata      <= cpu_wdata;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  a_bank_req_onehot: assert property (@(posedge CPU_CLK) disable iff (RST)
    $onehot0(bank_req));

endmodule

/* rtl/cache_bank.sv */
/*
 * One direct-mapped cache bank
 *  - tag, valid and data arrays indexed by address bits 7..2
 *  - hit compare with forced-miss override
 *  - FSM for lookup, memory wait and reply
 *  - write-through with allocate, refill on read miss
 */
`timescale 1ns/1ns

module cache_bank
(
  input  logic                CPU_CLK,
  input  logic                RST,
  input  logic                bank_req,
  input  logic                req_we,
  input  logic                req_force_miss,
  input  snowball_pkg::addr_t req_addr,
  input  snowball_pkg::data_t req_wdata,
  output logic                resp_valid,
  output snowball_pkg::data_t resp_data,
  output logic                mem_req,
  output logic                mem_req_we,
  output snowball_pkg::addr_t mem_req_addr,
  output snowball_pkg::data_t mem_req_wdata,
  input  logic                mem_done,
  input  snowball_pkg::data_t fill_data
);

  typedef enum logic [1:0]
  {
    IDLE,
    LOOKUP,
    MEM_WAIT,
    REPLY
  } bank_state_t;

  bank_state_t state;

  // ------------------------------------------------------------
  // Line storage
  // ------------------------------------------------------------
  snowball_pkg::tag_t  tag_mem  [snowball_pkg::LINES];
  snowball_pkg::data_t data_mem [snowball_pkg::LINES];
  logic [snowball_pkg::LINES-1:0] valid_bits;

  snowball_pkg::index_t req_index;
  snowball_pkg::tag_t   req_tag;
  snowball_pkg::data_t  line_wdata;
  logic                 hit;
  logic                 line_fill;

  assign req_index = req_addr[snowball_pkg::BANK_W +: snowball_pkg::INDEX_W];
  assign req_tag   = req_addr[snowball_pkg::BANK_W + snowball_pkg::INDEX_W +: snowball_pkg::TAG_W];

  assign hit = valid_bits[req_index] && (tag_mem[req_index] == req_tag) && !req_force_miss;

  assign line_wdata = req_we ? req_wdata : fill_data;      // Writes allocate the CPU data
  assign line_fill  = (state == MEM_WAIT) && mem_done;

  // ------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      state      <= IDLE;
      valid_bits <= '0;
    end
    else
    begin
      case (state)
        IDLE:
          if (bank_req)
            state <= LOOKUP;
        LOOKUP:
          if (hit && !req_we)
            state <= REPLY;                                 // Read hit
          else
            state <= MEM_WAIT;                              // Miss, forced miss or write
        MEM_WAIT:
          if (mem_done)
          begin
            valid_bits[req_index] <= 1'b1;
            state                 <= REPLY;
          end
        REPLY:
          state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  // Arrays and reply data. An older tag at the same index is simply replaced
  always_ff @(posedge CPU_CLK)
  begin
    if (line_fill)
    begin
      tag_mem[req_index]  <= req_tag;
      data_mem[req_index] <= line_wdata;
      resp_data           <= line_wdata;
    end
    else if (state == LOOKUP)
      resp_data <= data_mem[req_index];
  end

  // ------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------
  assign resp_valid    = (state == REPLY);
  assign mem_req       = (state == MEM_WAIT);              // Held until mem_done
  assign mem_req_we    = req_we;
  assign mem_req_addr  = req_addr;
  assign mem_req_wdata = req_wdata;

  a_req_resp_excl: assert property (@(posedge CPU_CLK) disable iff (RST)
    !(mem_req && resp_valid));

  // The arbiter may only answer a bank that is waiting on memory
  a_done_needs_req: assert property (@(posedge CPU_CLK) disable iff (RST)
    mem_done |-> mem_req);

endmodule

/* rtl/cache_refill_arbiter.sv */
/*
 * Refill arbiter
 *  - round-robin grant of bank requests to the memory port
 *  - memory handshake, request held until the ack pulse
 *  - mem_done pulse and fill data back to the granted bank
 *  - merge of bank responses into the CPU read data and done
 */
`timescale 1ns/1ns

module cache_refill_arbiter
(
  input  logic                                              CPU_CLK,
  input  logic                                              RST,
  input  logic [snowball_pkg::NUM_BANKS-1:0]                mem_req,
  input  logic [snowball_pkg::NUM_BANKS-1:0]                mem_req_we,
  input  snowball_pkg::addr_t [snowball_pkg::NUM_BANKS-1:0] mem_req_addr,
  input  snowball_pkg::data_t [snowball_pkg::NUM_BANKS-1:0] mem_req_wdata,
  input  logic [snowball_pkg::NUM_BANKS-1:0]                resp_valid,
  input  snowball_pkg::data_t [snowball_pkg::NUM_BANKS-1:0] resp_data,
  output logic [snowball_pkg::NUM_BANKS-1:0]                mem_done,
  output snowball_pkg::data_t                               fill_data,
  output snowball_pkg::data_t                               cpu_rdata,
  output logic                                              cpu_done,
  output logic                                              mem_do_act,
  output logic                                              mem_we,
  output snowball_pkg::addr_t                               mem_addr,
  output snowball_pkg::data_t                               mem_wdata,
  input  logic                                              mem_ack,
  input  snowball_pkg::data_t                               mem_rdata
);

  logic                    port_busy;   // From grant until mem_done has been sent
  logic                    start;
  snowball_pkg::bank_sel_t rr_ptr;
  snowball_pkg::bank_sel_t grant;
  snowball_pkg::bank_sel_t next_grant;

  // ------------------------------------------------------------
  // Round-robin pick, search starts at rr_ptr
  // ------------------------------------------------------------
  always_comb
  begin
    next_grant = rr_ptr;
    for (int i = snowball_pkg::NUM_BANKS - 1; i >= 0; i--)
    begin
      if (mem_req[snowball_pkg::bank_sel_t'(rr_ptr + i)])
        next_grant = snowball_pkg::bank_sel_t'(rr_ptr + i);  // Lowest offset wins
    end
  end

  assign start = !port_busy && (|mem_req);

  // ------------------------------------------------------------
  // Memory handshake
  // ------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (RST)
    begin
      port_busy  <= 1'b0;
      mem_do_act <= 1'b0;
      mem_done   <= '0;
      rr_ptr     <= '0;
    end
    else
    begin
      mem_done <= '0;
      if (start)
      begin
        port_busy  <= 1'b1;
        mem_do_act <= 1'b1;
        rr_ptr     <= snowball_pkg::bank_sel_t'(next_grant + 1'b1);
      end
      if (mem_do_act && mem_ack)
      begin
        mem_do_act      <= 1'b0;                            // Falls on the edge after ack
        mem_done[grant] <= 1'b1;
      end
      if (|mem_done)
        port_busy <= 1'b0;                                  // Bank has dropped mem_req by now
    end
  end

  // Address and data are frozen for the whole transaction
  always_ff @(posedge CPU_CLK)
  begin
    if (start)
    begin
      grant     <= next_grant;
      mem_we    <= mem_req_we[next_grant];
      mem_addr  <= mem_req_addr[next_grant];
      mem_wdata <= mem_req_wdata[next_grant];
    end
    if (mem_do_act && mem_ack)
      fill_data <= mem_rdata;
  end

  // ------------------------------------------------------------
  // CPU response merge
  // ------------------------------------------------------------
  always_comb
  begin
    cpu_rdata = '0;
    for (int i = 0; i < snowball_pkg::NUM_BANKS; i++)
    begin
      if (resp_valid[i])
        cpu_rdata = resp_data[i];
    end
  end

  assign cpu_done = |resp_valid;

  a_ack_in_txn: assert property (@(posedge CPU_CLK) disable iff (RST)
    mem_ack |-> mem_do_act);

  a_done_onehot: assert property (@(posedge CPU_CLK) disable iff (RST)
    $onehot0(mem_done));

endmodule

/* rtl/snowball_cache_top.sv */
/*
 * Cache top level
 *  - request steering block on the CPU side
 *  - four interleaved direct-mapped banks
 *  - refill arbiter towards the single memory port
 */
`timescale 1ns/1ns

module snowball_cache_top
(
  input  logic                CPU_CLK,
  input  logic                RST,
  input  logic                cpu_en,
  input  logic                cpu_we,
  input  logic                cpu_force_miss,
  input  snowball_pkg::addr_t cpu_addr,
  input  snowball_pkg::data_t cpu_wdata,
  output snowball_pkg::data_t cpu_rdata,
  output logic                cpu_busy,
  output logic                cpu_done,
  output logic                mem_do_act,
  output logic                mem_we,
  output snowball_pkg::addr_t mem_addr,
  output snowball_pkg::data_t mem_wdata,
  input  logic                mem_ack,
  input  snowball_pkg::data_t mem_rdata
);

  // ------------------------------------------------------------
  // Steer to banks
  // ------------------------------------------------------------
  logic [snowball_pkg::NUM_BANKS-1:0] bank_req;
  logic                               req_we;
  logic                               req_force_miss;
  snowball_pkg::addr_t                req_addr;
  snowball_pkg::data_t                req_wdata;

  // ------------------------------------------------------------
  // Banks to arbiter, one slot per bank
  // ------------------------------------------------------------
  logic [snowball_pkg::NUM_BANKS-1:0]                       mem_req;
  logic [snowball_pkg::NUM_BANKS-1:0]                       mem_req_we;
  snowball_pkg::addr_t [snowball_pkg::NUM_BANKS-1:0]        mem_req_addr;
  snowball_pkg::data_t [snowball_pkg::NUM_BANKS-1:0]        mem_req_wdata;
  logic [snowball_pkg::NUM_BANKS-1:0]                       resp_valid;
  snowball_pkg::data_t [snowball_pkg::NUM_BANKS-1:0]        resp_data;
  logic [snowball_pkg::NUM_BANKS-1:0]                       mem_done;
  snowball_pkg::data_t                                      fill_data;

  cache_request_steer i_steer
  (
    .CPU_CLK        (CPU_CLK),
    .RST            (RST),
    .cpu_en         (cpu_en),
    .cpu_we         (cpu_we),
    .cpu_force_miss (cpu_force_miss),
    .cpu_addr       (cpu_addr),
    .cpu_wdata      (cpu_wdata),
    .cpu_done       (cpu_done),
    .cpu_busy       (cpu_busy),
    .bank_req       (bank_req),
    .req_we         (req_we),
    .req_force_miss (req_force_miss),
    .req_addr       (req_addr),
    .req_wdata      (req_wdata)
  );

  for (genvar g = 0; g < snowball_pkg::NUM_BANKS; g++)
  begin : g_bank
    cache_bank i_bank
    (
      .CPU_CLK        (CPU_CLK),
      .RST            (RST),
      .bank_req       (bank_req[g]),
      .req_we         (req_we),
      .req_force_miss (req_force_miss),
      .req_addr       (req_addr),
      .req_wdata      (req_wdata),
      .resp_valid     (resp_valid[g]),
      .resp_data      (resp_data[g]),
      .mem_req        (mem_req[g]),
      .mem_req_we     (mem_req_we[g]),
      .mem_req_addr   (mem_req_addr[g]),
      .mem_req_wdata  (mem_req_wdata[g]),
      .mem_done       (mem_done[g]),
      .fill_data      (fill_data)
    );
  end

  cache_refill_arbiter i_arbiter
  (
    .CPU_CLK       (CPU_CLK),
    .RST           (RST),
    .mem_req       (mem_req),
    .mem_req_we    (mem_req_we),
    .mem_req_addr  (mem_req_addr),
    .mem_req_wdata (mem_req_wdata),
    .resp_valid    (resp_valid),
    .resp_data     (resp_data),
    .mem_done      (mem_done),
    .fill_data     (fill_data),
    .cpu_rdata     (cpu_rdata),
    .cpu_done      (cpu_done),
    .mem_do_act    (mem_do_act),
    .mem_we        (mem_we),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata)
  );

endmodule

/* tests/mem_model.sv */
/*
 * Behavioral word memory for the cache testbench
 *  - sparse storage, unwritten words read as address XOR A5A5_0000
 *  - acknowledge after 0 to 3 cycles drawn from a Galois LFSR
 *  - counts completed accesses
 */
`timescale 1ns/1ns

module mem_model
(
  input  logic                CPU_CLK,
  input  logic                RST,
  input  logic                mem_do_act,
  input  logic                mem_we,
  input  snowball_pkg::addr_t mem_addr,
  input  snowball_pkg::data_t mem_wdata,
  output logic                mem_ack,
  output snowball_pkg::data_t mem_rdata,
  output logic [31:0]         access_count
);

  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;     // x^32 + x^22 + x^2 + x + 1

  snowball_pkg::data_t words [snowball_pkg::addr_t];     // Only written words are stored
  logic [31:0]         lfsr = 32'h7089_78b5;
  logic                waiting = 1'b0;
  logic [1:0]          delay_left = 2'd0;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic snowball_pkg::data_t read_word(input snowball_pkg::addr_t a);
    if (words.exists(a))
      return words[a];
    return a ^ 32'hA5A5_0000;                             // Fresh content
  endfunction

  always @(posedge CPU_CLK)
  begin
    mem_ack <= 1'b0;
    if (RST)
    begin
      waiting      = 1'b0;
      mem_rdata    <= '0;
      access_count <= '0;
    end
    else if (mem_do_act && !mem_ack)                       // Request still high in its ack cycle
    begin
      if (!waiting)
      begin
        waiting    = 1'b1;
        delay_left = 2'd0;
        repeat (2)
        begin
          delay_left = {delay_left[0], lfsr[0]};          // One LFSR step per bit
          lfsr       = lfsr_step(lfsr);
        end
      end
      if (delay_left == 2'd0)
      begin
        waiting      = 1'b0;
        mem_ack      <= 1'b1;
        mem_rdata    <= read_word(mem_addr);
        access_count <= access_count + 32'd1;
        if (mem_we)
          words[mem_addr] = mem_wdata;
      end
      else
        delay_left = delay_left - 2'd1;
    end
  end

endmodule

/* tests/tb_snowball_cache.sv */
/*
 * Testbench for the four-bank write-through cache
 *  - clock, reset and the memory model
 *  - stimulus table of reads, writes, forced misses and resets
 *  - data, access count, done pulse and hit latency checks
 *  - cycle limit and the closing summary
 */
`timescale 1ns/1ns

module tb_snowball_cache;

  localparam logic [1:0] OP_READ  = 2'd0;
  localparam logic [1:0] OP_WRITE = 2'd1;
  localparam logic [1:0] OP_FORCE = 2'd2;
  localparam logic [1:0] OP_RESET = 2'd3;

  localparam int NUM_ROWS    = 13;
  localparam int MAX_DELAY   = 3;
  localparam int CYCLE_LIMIT = NUM_ROWS * (4 + MAX_DELAY + 6);

  localparam snowball_pkg::addr_t ADDR_A  = 32'h0000_0104;  // Bank 0, index 1
  localparam snowball_pkg::addr_t ADDR_B  = 32'h0000_0209;  // Bank 1, index 2
  localparam snowball_pkg::addr_t ADDR_C  = 32'h0001_0104;  // Same line as A, other tag
  localparam snowball_pkg::addr_t ADDR_D  = 32'h00AB_CDEF;  // Bank 3
  localparam snowball_pkg::addr_t BP_ADDR = 32'h0000_0302;  // Would miss if accepted
  localparam snowball_pkg::data_t WORD_W  = 32'h1234_5678;

  typedef struct packed
  {
    logic [1:0]          op;
    snowball_pkg::addr_t addr;
    snowball_pkg::data_t wdata;
    snowball_pkg::data_t exp_data;
    logic [31:0]         acc_delta;
    logic                hit_check;
    logic                bp;            // Extra enable pulse while busy
  } row_t;

  logic                CPU_CLK;
  logic                RST;
  logic                cpu_en;
  logic                cpu_we;
  logic                cpu_force_miss;
  snowball_pkg::addr_t cpu_addr;
  snowball_pkg::data_t cpu_wdata;
  snowball_pkg::data_t cpu_rdata;
  logic                cpu_busy;
  logic                cpu_done;
  logic                mem_do_act;
  logic                mem_we;
  snowball_pkg::addr_t mem_addr;
  snowball_pkg::data_t mem_wdata;
  logic                mem_ack;
  snowball_pkg::data_t mem_rdata;
  logic [31:0]         access_count;

  row_t        rows [NUM_ROWS];
  int          errors = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  logic [31:0] done_pulses = '0;

  snowball_cache_top i_dut
  (
    .CPU_CLK (CPU_CLK), .RST (RST), .cpu_en (cpu_en), .cpu_we (cpu_we),
    .cpu_force_miss (cpu_force_miss), .cpu_addr (cpu_addr), .cpu_wdata (cpu_wdata),
    .cpu_rdata (cpu_rdata), .cpu_busy (cpu_busy), .cpu_done (cpu_done),
    .mem_do_act (mem_do_act), .mem_we (mem_we), .mem_addr (mem_addr),
    .mem_wdata (mem_wdata), .mem_ack (mem_ack), .mem_rdata (mem_rdata)
  );

  mem_model i_mem
  (
    .CPU_CLK (CPU_CLK), .RST (RST), .mem_do_act (mem_do_act), .mem_we (mem_we),
    .mem_addr (mem_addr), .mem_wdata (mem_wdata), .mem_ack (mem_ack),
    .mem_rdata (mem_rdata), .access_count (access_count)
  );

  initial
  begin
    CPU_CLK = 1'b0;
    forever #10 CPU_CLK = ~CPU_CLK;
  end

  // ------------------------------------------------------------
  // Done pulse count and cycle limit
  // ------------------------------------------------------------
  always @(posedge CPU_CLK)
  begin
    cycles = cycles + 1;
    if (!RST && cpu_done)
      done_pulses = done_pulses + 32'd1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout, the table did not finish within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic snowball_pkg::data_t fresh_word(input snowball_pkg::addr_t a);
    return a ^ 32'hA5A5_0000;                               // Memory content before any write
  endfunction

  task automatic load_rows();
    rows[0]  = '{OP_READ,  ADDR_A, 32'h0, fresh_word(ADDR_A), 32'd1, 1'b0, 1'b0};
    rows[1]  = '{OP_READ,  ADDR_A, 32'h0, fresh_word(ADDR_A), 32'd0, 1'b1, 1'b0};
    rows[2]  = '{OP_WRITE, ADDR_B, WORD_W, WORD_W,            32'd1, 1'b0, 1'b0};
    rows[3]  = '{OP_READ,  ADDR_B, 32'h0, WORD_W,             32'd0, 1'b1, 1'b0};
    rows[4]  = '{OP_FORCE, ADDR_B, 32'h0, WORD_W,             32'd1, 1'b0, 1'b0};
    rows[5]  = '{OP_READ,  ADDR_C, 32'h0, fresh_word(ADDR_C), 32'd1, 1'b0, 1'b0};
    rows[6]  = '{OP_READ,  ADDR_B, 32'h0, WORD_W,             32'd0, 1'b1, 1'b0};
    rows[7]  = '{OP_READ,  ADDR_A, 32'h0, fresh_word(ADDR_A), 32'd1, 1'b0, 1'b0};
    rows[8]  = '{OP_READ,  ADDR_C, 32'h0, fresh_word(ADDR_C), 32'd1, 1'b0, 1'b0};
    rows[9]  = '{OP_RESET, ADDR_A, 32'h0, 32'h0,              32'd0, 1'b0, 1'b0};
    rows[10] = '{OP_READ,  ADDR_B, 32'h0, WORD_W,             32'd1, 1'b0, 1'b0};
    rows[11] = '{OP_READ,  ADDR_D, 32'h0, fresh_word(ADDR_D), 32'd1, 1'b0, 1'b1};
    rows[12] = '{OP_READ,  ADDR_D, 32'h0, fresh_word(ADDR_D), 32'd0, 1'b1, 1'b0};
  endtask

  task automatic apply_reset();
    RST = 1'b1;
    repeat (3) @(negedge CPU_CLK);
    RST = 1'b0;
  endtask

  // ------------------------------------------------------------
  // One table row, started and finished on a falling edge
  // ------------------------------------------------------------
  task automatic run_row(input int r);
    row_t                row;
    logic [31:0]         acc0;
    logic [31:0]         done0;
    snowball_pkg::data_t got;
    int                  lat;
    logic                seen;
    int                  bad;
    row = rows[r];
    bad = 0;
    if (row.op == OP_RESET)
    begin
      apply_reset();
      if (cpu_busy || mem_do_act)
      begin
        $display("cpu_busy or mem_do_act still high after reset");
        bad++;
      end
    end
    else
    begin
      while (cpu_busy)
        @(negedge CPU_CLK);
      acc0           = access_count;
      done0          = done_pulses;
      cpu_en         = 1'b1;
      cpu_we         = (row.op == OP_WRITE);
      cpu_force_miss = (row.op == OP_FORCE);
      cpu_addr       = row.addr;
      cpu_wdata      = row.wdata;
      @(posedge CPU_CLK);                                   // Acceptance edge
      lat  = 0;
      seen = 1'b0;
      while (!seen)
      begin
        @(negedge CPU_CLK);
        cpu_en   = row.bp && (lat == 0);
        cpu_addr = row.bp ? BP_ADDR : row.addr;
        if (cpu_done)
        begin
          seen = 1'b1;
          got  = cpu_rdata;
        end
        else
        begin
          @(posedge CPU_CLK);
          lat++;
        end
      end
      @(negedge CPU_CLK);
      if (got !== row.exp_data)
      begin
        $display("mismatch cpu_rdata test %0d exp %h got %h", r, row.exp_data, got);
        bad++;
      end
      if ((access_count - acc0) !== row.acc_delta)
      begin
        $display("mismatch access_count delta test %0d exp %h got %h", r, row.acc_delta,
                 access_count - acc0);
        bad++;
      end
      if ((done_pulses - done0) !== 32'd1)
      begin
        $display("mismatch cpu_done pulses test %0d exp %h got %h", r, 32'd1,
                 done_pulses - done0);
        bad++;
      end
      if (row.hit_check && lat != 2)
      begin
        $display("mismatch hit latency test %0d exp %h got %h", r, 2, lat);
        bad++;
      end
      if (cpu_busy)
      begin
        $display("cpu_busy still high one cycle after cpu_done in test %0d", r);
        bad++;
      end
    end
    errors += bad;
    if (bad != 0)
      tests_failed++;
    $display("test %2d op %0d addr %h: %0d failed checks", r, row.op, row.addr, bad);
  endtask

  initial
  begin
    RST            = 1'b1;
    cpu_en         = 1'b0;
    cpu_we         = 1'b0;
    cpu_force_miss = 1'b0;
    cpu_addr       = '0;
    cpu_wdata      = '0;
    load_rows();
    apply_reset();
    for (int r = 0; r < NUM_ROWS; r++)
      run_row(r);
    $display("tests %0d, failed %0d, failed checks %0d", NUM_ROWS, tests_failed, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

/* snowball_cache_top.f */
rtl/snowball_pkg.sv
rtl/cache_request_steer.sv
rtl/cache_bank.sv
rtl/cache_refill_arbiter.sv
rtl/snowball_cache_top.sv
tests/mem_model.sv
tests/tb_snowball_cache.sv

/* Makefile */
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= tb_snowball_cache
FILELIST  ?= snowball_cache_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
